//--- Bender.yml
package:
  name: rv_soc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/rv_bus_pkg.sv
      - hdl/rv_core.sv
      - hdl/rv_bus_fabric.sv
      - hdl/rv_key_port.sv
      - hdl/rv_art_port.sv
      - hdl/rv_soc_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_rv_soc.sv

//--- hdl/rv_art_port.sv
`timescale 1ns/1ps

module rv_art_port
    import rv_bus_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  art_write,       // decoded write strobe
    input  word_t bus_write_data,
    output word_t art_data,        // holds between stores
    output logic  art_valid        // one cycle per store
);

    always_ff @(posedge clk) begin
        if (art_write)
            art_data <= bus_write_data;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            art_valid <= 1'b0;
        else
            art_valid <= art_write;
    end

    // core never issues two stores back to back
    a_valid_pulse: assert property (@(posedge clk) disable iff (!reset)
        art_valid |=> !art_valid)
        else $error("art_valid held two cycles");

endmodule

//--- hdl/rv_bus_fabric.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_bus_fabric
    import rv_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bus_addr_t bus_address,
    input  logic      bus_write_enable,
    input  logic      bus_read_enable,
    output word_t     bus_read_data,    // one cycle after the read strobe
    output logic      key_read,
    input  key_code_t key_code,
    output logic      art_write
);

    logic hit_key;
    logic hit_art;

    // full address match, no aliasing
    assign hit_key = (bus_address == `RV_KEY_BASE);
    assign hit_art = (bus_address == `RV_ART_BASE);

    assign key_read  = bus_read_enable && hit_key;  // also clears the key irq
    assign art_write = bus_write_enable && hit_art;

    // read return path
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_read_data <= '0;
        end else if (bus_read_enable) begin
            bus_read_data <= hit_key ? word_t'(key_code) : '0; // unmapped reads give 0
        end
    end

    a_one_target: assert property (@(posedge clk) disable iff (!reset)
        !(key_read && art_write))
        else $error("bus strobe hits both ports");

endmodule

//--- hdl/rv_bus_pkg.sv
package rv_bus_pkg;

    // data path is a full 64 bit word
    typedef logic [63:0] word_t;

    typedef logic [63:0] bus_addr_t; // byte address, compared whole

    // raw code from the key input
    typedef logic [7:0] key_code_t;

    // interrupt cause seen by the core
    // zero means nothing pending
    typedef logic [3:0] irq_vec_t;

endpackage

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  instr_t    instruction,       // word at pc
    output pc_t       pc,
    output logic      heartbeat,
    input  irq_vec_t  interrupt_vector,
    output logic      interrupt_pending,
    output logic      interrupt_ack,
    output bus_addr_t bus_address,
    output word_t     bus_write_data,
    output logic      bus_write_enable,
    output logic      bus_read_enable,
    input  word_t     bus_read_data      // valid in STEP_FINISH
);

    localparam instr_t   IR_RESET = 32'h0000_0001; // decodes as nothing
    localparam reg_idx_t LOAD_RD  = 5'd5;          // load target and store source

    instr_t    ir;
    logic      bubble;     // squash the word now in ir
    exe_step_t step;
    logic      pend_load;  // op in flight is a load
    pc_t       mepc;
    word_t     regs [32];

    reg_idx_t  rd;
    word_t     imm_u;
    logic      is_lui;
    logic      is_mret;
    logic      is_load;
    logic      is_store;
    logic      irq_take;
    logic      exec_ok;

    assign rd    = ir[11:7];
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0}; // sign extended upper imm

    assign is_lui   = (ir[6:0] == OP_LUI);
    assign is_mret  = (ir == INSTR_MRET);
    assign is_load  = (ir == INSTR_LOAD_KEY);
    assign is_store = (ir == INSTR_STORE_ART);

    // only at a clean boundary, so pc - 4 really is the word in ir
    assign irq_take = (interrupt_vector == `RV_KEY_IRQ) && !interrupt_pending &&
                      !bubble && (step == STEP_ISSUE);
    assign exec_ok  = !irq_take && !bubble && (step == STEP_ISSUE);

    // strobes leave during issue, peripherals register them
    assign bus_read_enable  = exec_ok && is_load;
    assign bus_write_enable = exec_ok && is_store;
    assign bus_address      = is_store ? `RV_ART_BASE : (is_load ? `RV_KEY_BASE : '0);
    assign bus_write_data   = regs[LOAD_RD];

    // fetch stage
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= IR_RESET;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    // execute control
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc                <= `RV_RESET_PC;
            bubble            <= 1'b0;
            step              <= STEP_ISSUE;
            pend_load         <= 1'b0;
            interrupt_pending <= 1'b0;
            interrupt_ack     <= 1'b0;
        end else begin
            pc            <= pc + 32'd4; // default, overridden below
            bubble        <= 1'b0;
            interrupt_ack <= 1'b0;
            if (irq_take) begin
                pc                <= `RV_TRAP_PC;
                bubble            <= 1'b1; // next ir is the stale fetch
                interrupt_pending <= 1'b1;
                interrupt_ack     <= 1'b1;
            end else if (step == STEP_FINISH) begin
                step <= STEP_ISSUE; // word in ir gets refetched
            end else if (exec_ok) begin
                if (is_mret) begin
                    pc                <= mepc;
                    bubble            <= 1'b1;
                    interrupt_pending <= 1'b0;
                end else if (is_load || is_store) begin
                    pc        <= pc; // hold one cycle
                    step      <= STEP_FINISH;
                    pend_load <= is_load;
                end
            end
        end
    end

    // return address of the interrupted word
    always_ff @(posedge clk) begin
        if (irq_take)
            mepc <= pc - 32'd4;
    end

    // register file, lui in issue and load data in finish
    always_ff @(posedge clk) begin
        if (exec_ok && is_lui)
            regs[rd] <= imm_u;
        else if ((step == STEP_FINISH) && pend_load)
            regs[LOAD_RD] <= bus_read_data;
    end

    // finish step always sits between two bus ops
    a_bus_excl: assert property (@(posedge clk) disable iff (!reset)
        (bus_read_enable || bus_write_enable) |=> !(bus_read_enable || bus_write_enable))
        else $error("bus strobes in two consecutive cycles");

    // pending blocks re-entry until mret
    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack)
        else $error("interrupt_ack held two cycles");

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // fetched word and fetch address
    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;

    typedef logic [4:0] reg_idx_t; // rd field, 32 registers

    // two cycle bus ops
    typedef enum logic {
        STEP_ISSUE,  // strobe out, pc held
        STEP_FINISH  // read data back, refetched word dropped
    } exe_step_t;

    localparam logic [6:0] OP_LUI = 7'b0110111; // major opcode, low 7 bits

    // custom whole-word encodings
    localparam instr_t INSTR_MRET      = 32'h0000_0000; // all zeros
    localparam instr_t INSTR_LOAD_KEY  = 32'hFFFF_FFFF; // all ones
    localparam instr_t INSTR_STORE_ART = 32'hFFFF_FF7F; // all ones, rd = 30

endpackage

//--- hdl/rv_key_port.sv
`timescale 1ns/1ps

module rv_key_port
    import rv_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  key_code_t key_data,
    input  logic      key_strobe,  // one cycle, from the keyboard side
    input  logic      key_read,    // read strobe from the fabric
    output key_code_t key_code,
    output logic      key_irq      // level until the code is read
);

    // last code seen, held until overwritten
    always_ff @(posedge clk) begin
        if (key_strobe)
            key_code <= key_data;
    end

    // pending flag
    // strobe checked first so a key arriving with the read survives
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_irq <= 1'b0;
        end else if (key_strobe) begin
            key_irq <= 1'b1;
        end else if (key_read) begin
            key_irq <= 1'b0;
        end
    end

endmodule

//--- hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// pc after reset, first word of main code
`define RV_RESET_PC 32'h0000_1000

// interrupt entry, service routine lives here
`define RV_TRAP_PC 32'h0000_0000

// peripheral bases on the data bus
`define RV_KEY_BASE 64'h0000_0000_1000_0000 // key input port
`define RV_ART_BASE 64'h0000_0000_2000_0000 // art output port

// vector code driven while the key port has a code waiting
`define RV_KEY_IRQ 4'd1

`endif

//--- hdl/rv_soc_top.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_soc_top
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  instr_t    instruction,   // from external program memory
    output pc_t       pc,
    output logic      heartbeat,
    input  key_code_t key_data,
    input  logic      key_strobe,
    output logic      interrupt_ack,
    output word_t     art_data,
    output logic      art_valid
);

    bus_addr_t bus_address;
    word_t     bus_write_data;
    logic      bus_write_enable;
    logic      bus_read_enable;
    word_t     bus_read_data;
    logic      key_read;
    logic      art_write;
    key_code_t key_code;
    logic      key_irq;
    irq_vec_t  interrupt_vector;

    // single source for now
    assign interrupt_vector = key_irq ? `RV_KEY_IRQ : '0;

    rv_core u_core (
        .clk               (clk),
        .reset             (reset),
        .instruction       (instruction),
        .pc                (pc),
        .heartbeat         (heartbeat),
        .interrupt_vector  (interrupt_vector),
        .interrupt_pending (),               // internal to the core here
        .interrupt_ack     (interrupt_ack),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_data     (bus_read_data)
    );

    rv_bus_fabric u_fabric (
        .clk              (clk),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_read         (key_read),
        .key_code         (key_code),
        .art_write        (art_write)
    );

    rv_key_port u_key (
        .clk        (clk),
        .reset      (reset),
        .key_data   (key_data),
        .key_strobe (key_strobe),
        .key_read   (key_read),
        .key_code   (key_code),
        .key_irq    (key_irq)
    );

    rv_art_port u_art (
        .clk            (clk),
        .reset          (reset),
        .art_write      (art_write),
        .bus_write_data (bus_write_data),
        .art_data       (art_data),
        .art_valid      (art_valid)
    );

endmodule

//--- rv_soc.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_bus_pkg.sv
hdl/rv_core.sv
hdl/rv_bus_fabric.sv
hdl/rv_key_port.sv
hdl/rv_art_port.sv
hdl/rv_soc_top.sv
testbench/tb_rv_soc.sv

//--- testbench/tb_rv_soc.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_soc
    import rv_isa_pkg::*;
    import rv_bus_pkg::*;
();

    localparam int        MAIN_WORDS  = 4096;          // main code words from the reset pc
    localparam int        RAND_CYCLES = 2000;
    localparam int        WAIT_LIMIT  = 120;           // one key, whole service round trip
    localparam int        RUN_CYCLES  = 5 + 4 + 40 + 1 + WAIT_LIMIT + RAND_CYCLES;
    localparam instr_t    NOP_WORD    = 32'h0000_0013; // addi x0, x0, 0
    localparam key_code_t INIT_CODE   = 8'h3c;         // latched while reset is low

    logic      clk, reset, heartbeat, key_strobe, interrupt_ack, art_valid;
    instr_t    instruction;
    pc_t       pc;
    key_code_t key_data;
    word_t     art_data;

    instr_t      main_code [MAIN_WORDS];
    logic [31:0] seed = 32'h928d1829;
    int          errors = 0, checks = 0, tests_run = 0, tests_failed = 0, errors_before = 0;
    int          dut_arts = 0, model_arts = 0;

    // cycle model of core and ports, reset values
    pc_t       m_pc = `RV_RESET_PC, m_mepc;
    instr_t    m_ir = NOP_WORD;                  // decodes as nothing
    logic      m_bubble = 1'b0, m_finish = 1'b0, m_load = 1'b0, m_pending = 1'b0;
    logic      m_ack = 1'b0, m_hb = 1'b0, m_key_irq = 1'b0, m_art_valid = 1'b0;
    key_code_t m_key_code = INIT_CODE;
    word_t     m_rdata = '0, m_art_data;
    word_t     m_regs [32];

    rv_soc_top u_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk; // 8 ns period

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223; // lcg step
        return seed;
    endfunction

    // program memory, service routine echoes the key and returns
    function automatic instr_t fetch_word(pc_t addr);
        if (addr == `RV_TRAP_PC)
            return INSTR_LOAD_KEY;
        if (addr == `RV_TRAP_PC + 32'd4)
            return INSTR_STORE_ART;
        if (addr == `RV_TRAP_PC + 32'd8)
            return INSTR_MRET;
        if (addr >= `RV_RESET_PC && addr < `RV_RESET_PC + 4 * MAIN_WORDS)
            return main_code[(addr - `RV_RESET_PC) >> 2];
        return NOP_WORD; // unused space
    endfunction

    task automatic build_program();
        logic [31:0] sel;
        logic [31:0] imm;
        reg_idx_t    rd;
        for (int i = 0; i < MAIN_WORDS; i++) begin
            sel = next_random(); // high bits only, lcg low bits are weak
            imm = next_random();
            rd  = sel[27] ? 5'd5 : sel[26:22]; // x5 often, it feeds the art port
            case (sel[31:29])
                3'd0, 3'd1, 3'd2: main_code[i] = {imm[31:12], rd, OP_LUI};
                3'd3, 3'd4:       main_code[i] = NOP_WORD;
                3'd5:             main_code[i] = INSTR_LOAD_KEY;
                default:          main_code[i] = INSTR_STORE_ART;
            endcase
        end
        main_code[0] = {imm[31:12], 5'd5, OP_LUI}; // x5 known before any store
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1)
        else begin
            errors++;
            $display("failure at %0t ns, %s", $time, what);
        end
    endtask

    // judged on errors since the previous test
    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // one edge, everything from the state before it
    task automatic advance_model();
        logic take, exec, load, store;
        take  = m_key_irq && !m_pending && !m_bubble && !m_finish;
        exec  = !take && !m_bubble && !m_finish;
        load  = exec && (m_ir == INSTR_LOAD_KEY);
        store = exec && (m_ir == INSTR_STORE_ART);
        m_ack       = take;
        m_art_valid = store;
        model_arts += store;
        if (store)
            m_art_data = m_regs[5];          // x5 is the store source
        if (m_finish && m_load)
            m_regs[5] = m_rdata;             // load lands in the second step
        if (load)
            m_rdata = word_t'(m_key_code);   // zero extended
        if (key_strobe)
            m_key_irq = 1'b1;                // new key beats the read
        else if (load)
            m_key_irq = 1'b0;
        if (key_strobe)
            m_key_code = key_data;
        m_bubble = 1'b0;
        if (take) begin
            m_mepc    = m_pc - 32'd4;        // word in ir, redone on return
            m_pc      = `RV_TRAP_PC;
            m_bubble  = 1'b1;
            m_pending = 1'b1;
        end else if (m_finish) begin
            m_finish = 1'b0;
            m_pc     = m_pc + 32'd4;
        end else if (exec && m_ir == INSTR_MRET) begin
            m_pc      = m_mepc;
            m_bubble  = 1'b1;
            m_pending = 1'b0;
        end else if (load || store) begin
            m_finish = 1'b1;                 // pc holds one cycle
            m_load   = load;
        end else begin
            // upper immediate over 12 zero bits, widened as a signed value
            if (exec && m_ir[6:0] == OP_LUI)
                m_regs[m_ir[11:7]] = $signed({m_ir[31:12], 12'h000});
            m_pc = m_pc + 32'd4;
        end
        m_ir = instruction;
        m_hb = ~m_hb;
    endtask

    // model first, then compare after the edge and drive the next inputs
    task automatic step_cycle(input logic strobe, input key_code_t code);
        advance_model();
        @(posedge clk);
        #1;
        check_value("pc", m_pc, pc);
        check_value("interrupt_ack", m_ack, interrupt_ack);
        check_value("art_valid", m_art_valid, art_valid);
        check_value("heartbeat", m_hb, heartbeat);
        if (m_art_valid)
            check_value("art_data", m_art_data, art_data);
        dut_arts   += art_valid;
        instruction = fetch_word(pc); // memory answers the pc just issued
        key_strobe  = strobe;
        key_data    = code;
    endtask

    initial begin
        logic [31:0] r;
        key_code_t   code;
        pc_t         prev_pc, ret_pc, entry_pc;
        word_t       echo_data;
        logic        echoed, returned;
        int          holds, acks;
        build_program();
        reset       = 1'b0;
        key_strobe  = 1'b1; // known code in the key register, irq held clear by reset
        key_data    = INIT_CODE;
        instruction = fetch_word(`RV_RESET_PC);
        repeat (5) @(posedge clk);
        #1;
        reset      = 1'b1;
        key_strobe = 1'b0;

        check_value("pc", `RV_RESET_PC, pc);
        check_value("art_valid", 1'b0, art_valid);
        check_value("interrupt_ack", 1'b0, interrupt_ack);
        check_value("heartbeat", 1'b0, heartbeat);
        repeat (4) step_cycle(1'b0, 8'h00); // heartbeat toggle via the model
        end_test("reset state");

        holds = 0;
        for (int n = 0; n < 40; n++) begin
            prev_pc = pc;
            step_cycle(1'b0, 8'h00);
            holds += (pc == prev_pc);
        end
        check_true(holds > 0, "no load or store held pc in straight-line code");
        end_test("straight-line pc");

        // one key through the service routine
        r        = next_random();
        code     = r[23:16];
        acks     = 0;
        echoed   = 1'b0;
        returned = 1'b0;
        step_cycle(1'b1, code);
        for (int n = 0; n < WAIT_LIMIT && !returned; n++) begin
            step_cycle(1'b0, code);
            if (interrupt_ack && acks == 0) begin
                ret_pc   = m_mepc;
                entry_pc = pc;
            end
            if (art_valid && acks > 0 && !echoed) begin
                echoed    = 1'b1;  // store inside the routine
                echo_data = art_data;
            end
            acks    += interrupt_ack;
            returned = (acks > 0) && (pc >= `RV_RESET_PC); // back in main code
        end
        check_true(acks > 0, "no interrupt_ack after a key strobe");
        check_value("pc at interrupt entry", `RV_TRAP_PC, entry_pc);
        end_test("key interrupt entry");
        check_true(echoed, "service routine produced no art output");
        check_value("art_data", word_t'(code), echo_data);
        end_test("key echo");
        check_true(returned, "no return from the service routine");
        check_true(acks == 1, "second interrupt_ack before mret");
        check_value("pc after mret", ret_pc, pc);
        end_test("return from interrupt");

        dut_arts   = 0;
        model_arts = 0;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            r = next_random();
            step_cycle(r[31:27] == 5'd0, r[23:16]); // about one key in 32 cycles
        end
        check_value("art output count", model_arts, dut_arts);
        end_test("random run");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        #(8 * (RUN_CYCLES + 100));
        $display("watchdog expired after %0d cycles, run did not finish", RUN_CYCLES + 100);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
